// ==== tb.f ====
armPkg.sv
memBus.sv
alu.sv
memArbiter.sv
unifiedMem.sv
controller.sv
hazardUnit.sv
datapath.sv
armSystem.sv
tbArmSystem.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tbArmSystem -o simArm
./obj_dir/simArm | tee sim.log

if grep -q "TEST PASS" sim.log; then
  exit 0
else
  exit 1
fi

// ==== tbArmSystem.sv ====
module tbArmSystem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MemWords = 256;
  localparam logic [3:0] CmdAnd = 4'h0;
  localparam logic [3:0] CmdSub = 4'h2;
  localparam logic [3:0] CmdAdd = 4'h4;
  localparam logic [3:0] CmdCmp = 4'hA;
  localparam logic [3:0] CmdOrr = 4'hC;
  localparam logic [3:0] CondEq = 4'h0;
  localparam logic [3:0] CondNe = 4'h1;
  localparam logic [3:0] CondAl = 4'hE;
  localparam logic [23:0] OffSelf = 24'hFF_FFFE;  // B to itself, ends a program

  logic clk;
  logic reset;
  logic loadValid;
  logic loadReady;
  logic [armPkg::DataWidth-1:0] loadAddr;  // Word address
  logic [armPkg::DataWidth-1:0] loadData;
  logic retireValid;
  logic [armPkg::RegAddrWidth-1:0] retireReg;
  logic [armPkg::DataWidth-1:0] retireData;

  logic [31:0] prog [$];  // Program of the running test
  logic [armPkg::RegAddrWidth-1:0] expReg [$];  // Model retire trace
  logic [armPkg::DataWidth-1:0] expVal [$];
  logic [armPkg::DataWidth-1:0] mReg [16];
  logic [armPkg::DataWidth-1:0] mMem [MemWords];
  logic mZ;  // Model Z flag
  logic [31:0] lfsr = 32'hb39c_c10d;
  int budget = 10;  // Watchdog limit in cycles, grows with each program
  int errRetire = 0;
  int errCount = 0;
  int errOther = 0;
  string testName;

  armSystem #(.MemWords(MemWords)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsrBits(input int n);
    logic [31:0] bits;
    logic fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [31:0] dpImm(input logic [3:0] cmd, input logic [3:0] rd,
                                        input logic [3:0] rn, input logic [3:0] rot,
                                        input logic [7:0] imm8);
    return {CondAl, 3'b001, cmd, cmd == CmdCmp, rn, rd, rot, imm8};  // S only on CMP
  endfunction

  function automatic logic [31:0] dpReg(input logic [3:0] cmd, input logic [3:0] rd,
                                        input logic [3:0] rn, input logic [3:0] rm);
    return {CondAl, 3'b000, cmd, cmd == CmdCmp, rn, rd, 8'h00, rm};
  endfunction

  function automatic logic [31:0] memOp(input logic load, input logic [3:0] rd,
                                        input logic [3:0] rn, input logic [11:0] off);
    return {CondAl, 3'b010, 4'b1100, load, rn, rd, off};  // Pre-indexed, offset added
  endfunction

  function automatic logic [31:0] branchOp(input logic [3:0] cond, input logic [23:0] off);
    return {cond, 4'b1010, off};
  endfunction

  function automatic logic [31:0] rotRight(input logic [7:0] imm8, input logic [3:0] rot);
    logic [31:0] v;
    v = {24'h0, imm8};
    repeat (2 * rot) v = {v[0], v[31:1]};
    return v;
  endfunction

  function automatic logic [31:0] readModel(input logic [3:0] r, input logic [31:0] pc);
    return (r == 4'hF) ? pc + 8 : mReg[r];  // R15 is PC+8
  endfunction

  task automatic modelWrite(input logic [3:0] rd, input logic [31:0] val);
    mReg[rd] = val;
    expReg.push_back(rd);
    expVal.push_back(val);
  endtask

  // Runs prog by the ISA rules until the branch to itself
  task automatic runModel();
    logic [31:0] pc, w, a, b, res, target;
    logic pass;
    expReg.delete();
    expVal.delete();
    foreach (mMem[i]) mMem[i] = '0;
    foreach (prog[i]) mMem[i] = prog[i];
    mZ = 1'b0;
    pc = '0;
    for (int steps = 0; steps < 2000; steps++) begin
      w = mMem[pc[9:2]];
      pass = (w[31:28] == CondAl) || (w[31:28] == CondEq && mZ)
          || (w[31:28] == CondNe && !mZ);
      a = readModel(w[19:16], pc);
      if (w[27:26] == 2'b10) begin
        target = pc + 8 + {{6{w[23]}}, w[23:0], 2'b00};
        if (pass && target == pc)
          break;
        pc = pass ? target : pc + 4;
      end else if (w[27:26] == 2'b01) begin
        a = a + {20'h0, w[11:0]};  // Byte address
        if (pass && w[20])
          modelWrite(w[15:12], mMem[a[9:2]]);
        else if (pass)
          mMem[a[9:2]] = readModel(w[15:12], pc);
        pc = pc + 4;
      end else begin
        b = w[25] ? rotRight(w[7:0], w[11:8]) : readModel(w[3:0], pc);
        case (w[24:21])
          CmdAdd: res = a + b;
          CmdAnd: res = a & b;
          CmdOrr: res = a | b;
          default: res = a - b;  // SUB, CMP
        endcase
        if (w[24:21] == CmdCmp)
          mZ = (res == '0);
        else if (pass)
          modelWrite(w[15:12], res);
        pc = pc + 4;
      end
    end
  endtask

  task automatic checkRetire(input logic [armPkg::RegAddrWidth-1:0] wantReg,
                             input logic [armPkg::DataWidth-1:0] wantData,
                             input logic [armPkg::RegAddrWidth-1:0] gotReg,
                             input logic [armPkg::DataWidth-1:0] gotData);
    if (gotReg !== wantReg || gotData !== wantData) begin
      errRetire++;
      $display("Fail %0t: %s retired r%0d = %h, expected r%0d = %h", $time, testName,
               gotReg, gotData, wantReg, wantData);
    end
  endtask

  task automatic checkCount(input int want, input int got);
    if (got != want) begin
      errCount++;
      $display("Fail %0t: %s had %0d retirements, expected %0d", $time, testName, got, want);
    end
  endtask

  task automatic loadWord(input logic [31:0] addr, input logic [31:0] data);
    int tries;
    @(negedge clk);
    loadValid = 1'b1;
    loadAddr = addr;
    loadData = data;
    tries = 0;
    do begin
      @(posedge clk);  // Word is written at this edge if ready
      tries++;
    end while (!loadReady && tries < 20);
    if (!loadReady) begin
      errOther++;
      $display("%s: load port never became ready for word %0d", testName, addr);
    end
  endtask

  // Retires are sampled mid-cycle, stop a few cycles after the last expected one
  task automatic collectRetires(input int limit);
    int got, cycles, idle;
    got = 0;
    cycles = 0;
    idle = 0;
    while (cycles < limit && idle < 12) begin
      @(negedge clk);
      cycles++;
      if (retireValid) begin
        if (got < expReg.size())
          checkRetire(expReg[got], expVal[got], retireReg, retireData);
        got++;
      end
      if (got >= expReg.size())
        idle++;
    end
    checkCount(expReg.size(), got);
  endtask

  // Load under reset, then let the core run
  task automatic runProgram(input string name);
    testName = name;
    budget += 40 * prog.size();
    runModel();
    @(negedge clk);
    reset = 1'b1;
    repeat (3) @(negedge clk);
    foreach (prog[i]) loadWord(i, prog[i]);
    @(negedge clk);
    loadValid = 1'b0;
    reset = 1'b0;
    collectRetires(25 * prog.size());
  endtask

  task automatic immAluOps();
    prog.delete();
    prog.push_back(dpImm(CmdAnd, 4'd0, 4'd0, 4'd0, 8'h00));
    prog.push_back(dpImm(CmdAdd, 4'd1, 4'd0, 4'd14, 8'h3F));  // 0x3F0
    prog.push_back(dpImm(CmdOrr, 4'd2, 4'd0, 4'd4, 8'hFF));  // 0xFF000000
    prog.push_back(dpImm(CmdSub, 4'd3, 4'd1, 4'd0, 8'h01));
    prog.push_back(dpImm(CmdAnd, 4'd4, 4'd2, 4'd4, 8'h0F));
    prog.push_back(dpImm(CmdSub, 4'd5, 4'd0, 4'd0, 8'h01));  // Wraps to all ones
    prog.push_back(branchOp(CondAl, OffSelf));
    runProgram("immediate ALU");
  endtask

  task automatic forwardChain();
    prog.delete();
    prog.push_back(dpImm(CmdAnd, 4'd5, 4'd5, 4'd0, 8'h00));
    prog.push_back(dpImm(CmdAdd, 4'd5, 4'd5, 4'd0, 8'h07));
    prog.push_back(dpReg(CmdAdd, 4'd6, 4'd5, 4'd5));  // Both from M
    prog.push_back(dpReg(CmdOrr, 4'd7, 4'd6, 4'd5));  // M and W
    prog.push_back(dpReg(CmdSub, 4'd8, 4'd7, 4'd5));
    prog.push_back(dpReg(CmdAdd, 4'd9, 4'd8, 4'd6));  // Distance 3 through the register file
    prog.push_back(dpReg(CmdAnd, 4'd10, 4'd9, 4'd7));
    prog.push_back(branchOp(CondAl, OffSelf));
    runProgram("forwarding");
  endtask

  task automatic storeLoad();
    prog.delete();
    prog.push_back(dpImm(CmdAnd, 4'd0, 4'd0, 4'd0, 8'h00));
    prog.push_back(dpImm(CmdAdd, 4'd1, 4'd0, 4'd0, 8'h55));
    prog.push_back(dpImm(CmdOrr, 4'd1, 4'd1, 4'd4, 8'hAB));
    prog.push_back(memOp(1'b0, 4'd1, 4'd0, 12'h200));  // Word 128
    prog.push_back(memOp(1'b1, 4'd2, 4'd0, 12'h200));
    prog.push_back(dpImm(CmdAdd, 4'd3, 4'd2, 4'd0, 8'h01));  // Load-use
    prog.push_back(memOp(1'b0, 4'd3, 4'd0, 12'h204));
    prog.push_back(memOp(1'b1, 4'd4, 4'd0, 12'h204));
    prog.push_back(dpReg(CmdOrr, 4'd5, 4'd4, 4'd2));
    prog.push_back(branchOp(CondAl, OffSelf));
    runProgram("store and load");
  endtask

  task automatic branchLoop();
    prog.delete();
    prog.push_back(dpImm(CmdAnd, 4'd0, 4'd0, 4'd0, 8'h00));
    prog.push_back(branchOp(CondAl, 24'h00_0000));  // Skips the next word
    prog.push_back(dpImm(CmdAdd, 4'd9, 4'd0, 4'd0, 8'd99));
    prog.push_back(dpImm(CmdAnd, 4'd1, 4'd1, 4'd0, 8'h00));
    prog.push_back(dpImm(CmdAdd, 4'd1, 4'd1, 4'd0, 8'h04));
    prog.push_back(dpImm(CmdSub, 4'd1, 4'd1, 4'd0, 8'h01));  // Loop head
    prog.push_back(dpImm(CmdCmp, 4'd0, 4'd1, 4'd0, 8'h00));
    prog.push_back(branchOp(CondNe, 24'hFF_FFFC));
    prog.push_back(branchOp(CondEq, 24'h00_0000));  // Z set after the loop
    prog.push_back(dpImm(CmdAdd, 4'd9, 4'd0, 4'd0, 8'd77));
    prog.push_back(dpImm(CmdAdd, 4'd2, 4'd1, 4'd0, 8'h03));
    prog.push_back(branchOp(CondAl, OffSelf));
    runProgram("branches");
  endtask

  task automatic randomPrograms();
    logic [31:0] r;
    logic [3:0] cmd;
    for (int round = 0; round < 2; round++) begin
      prog.delete();
      for (int i = 0; i < 8; i++) begin  // Known start values in r0..r7
        r = lfsrBits(12);
        prog.push_back(dpImm(CmdAnd, i[3:0], i[3:0], 4'd0, 8'h00));
        prog.push_back(dpImm(CmdOrr, i[3:0], i[3:0], r[11:8], r[7:0]));
      end
      for (int i = 0; i < 16; i++) begin
        r = lfsrBits(24);
        case (r[23:22])
          2'd0: cmd = CmdAnd;
          2'd1: cmd = CmdSub;
          2'd2: cmd = CmdAdd;
          default: cmd = CmdOrr;
        endcase
        if (r[21])
          prog.push_back(dpImm(cmd, {1'b0, r[20:18]}, {1'b0, r[17:15]}, r[11:8], r[7:0]));
        else
          prog.push_back(dpReg(cmd, {1'b0, r[20:18]}, {1'b0, r[17:15]}, {1'b0, r[14:12]}));
      end
      prog.push_back(branchOp(CondAl, OffSelf));
      runProgram($sformatf("random program %0d", round));
    end
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= budget) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    reset = 1'b1;
    loadValid = 1'b0;
    loadAddr = '0;
    loadData = '0;
    testName = "reset";
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (retireValid || loadReady) begin
      errOther++;
      $display("Retire or load ready was high right after reset");
    end
    immAluOps();
    forwardChain();
    storeLoad();
    branchLoop();
    randomPrograms();
    $display("Errors: %0d retire, %0d count, %0d other", errRetire, errCount, errOther);
    if (errRetire + errCount + errOther == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end
endmodule

// ==== armSystem.sv ====
module armSystem #(
  parameter int MemWords = 256
) (
  input logic clk,
  input logic reset,
  input logic loadValid,
  output logic loadReady,
  input logic [armPkg::DataWidth-1:0] loadAddr,  // Word address
  input logic [armPkg::DataWidth-1:0] loadData,
  output logic retireValid,
  output logic [armPkg::RegAddrWidth-1:0] retireReg,
  output logic [armPkg::DataWidth-1:0] retireData
);
  memBus loadBus ();
  memBus fetchBus ();
  memBus dataBus ();

  logic [armPkg::DataWidth-1:0] instrD;
  armPkg::stageCtrl ctrlE;
  armPkg::stageCtrl ctrlM;
  armPkg::stageCtrl ctrlW;
  armPkg::immSrc immSrcD;
  logic [1:0] regSrcD;
  logic BranchTakenE;
  logic zeroE;
  logic fetchWait;
  logic Match1EM;
  logic Match1EW;
  logic Match2EM;
  logic Match2EW;
  logic Match12DE;
  armPkg::forwardSel ForwardAE;
  armPkg::forwardSel ForwardBE;
  logic StallF;
  logic StallD;
  logic FlushD;
  logic FlushE;
  armPkg::memReq memOut;
  logic memWe;
  logic [armPkg::DataWidth-1:0] memRdata;

  // Loader only writes
  assign loadBus.valid = loadValid;
  assign loadBus.req = '{addr: loadAddr, wdata: loadData, we: 1'b1};
  assign loadReady = loadBus.ready;

  datapath dp (
    .fetchPort(fetchBus),
    .dataPort(dataBus),
    .*
  );

  controller ctl (.*);

  hazardUnit hzd (.*);

  memArbiter #(
    .MemWords(MemWords)
  ) arb (
    .clk(clk),
    .reset(reset),
    .loadPort(loadBus),
    .dataPort(dataBus),
    .fetchPort(fetchBus),
    .memOut(memOut),
    .memWe(memWe),
    .memRdata(memRdata)
  );

  unifiedMem #(
    .MemWords(MemWords)
  ) mem (
    .clk(clk),
    .memIn(memOut),
    .memWe(memWe),
    .memRdata(memRdata)
  );
endmodule

// ==== datapath.sv ====
module datapath (
  input logic clk,
  input logic reset,
  memBus.requester fetchPort,
  memBus.requester dataPort,
  output logic [armPkg::DataWidth-1:0] instrD,
  input armPkg::stageCtrl ctrlE,
  input armPkg::stageCtrl ctrlM,
  input armPkg::stageCtrl ctrlW,
  input armPkg::immSrc immSrcD,
  input logic [1:0] regSrcD,
  input logic BranchTakenE,
  input armPkg::forwardSel ForwardAE,
  input armPkg::forwardSel ForwardBE,
  input logic StallF,
  input logic StallD,
  input logic FlushD,
  output logic zeroE,
  output logic Match1EM,
  output logic Match1EW,
  output logic Match2EM,
  output logic Match2EW,
  output logic Match12DE,
  output logic fetchWait,
  output logic retireValid,
  output logic [armPkg::RegAddrWidth-1:0] retireReg,
  output logic [armPkg::DataWidth-1:0] retireData
);
  localparam int Dw = armPkg::DataWidth;
  localparam int Ra = armPkg::RegAddrWidth;
  localparam logic [Dw-1:0] NopInstr = 32'hF000_0000;  // AND with never cond

  logic fetchEnQ;  // Fetch starts one cycle after reset
  logic [Dw-1:0] pcF;
  logic [Dw-1:0] pcPlus4F;  // Also R15 (PC+8) of the instruction in D
  logic [Ra-1:0] ra1D, ra2D;
  logic [Dw-1:0] rd1D, rd2D, extImmD;
  logic [2*Dw-1:0] rotImmD;
  logic [Dw-1:0] regs [2**Ra];
  logic [Dw-1:0] rd1E, rd2E, extImmE;
  logic [Ra-1:0] ra1E, ra2E, wa3E;
  logic [Dw-1:0] srcAE, writeDataE, srcBE, aluResultE;
  logic [Dw-1:0] aluOutM, writeDataM;
  logic [Ra-1:0] wa3M, wa3W;
  logic [Dw-1:0] aluOutW, readDataW, resultW;

  // R15 reads as PC+8, a write still in W goes straight to the reader
  function automatic logic [Dw-1:0] readReg(input logic [Ra-1:0] ra);
    if (ra == {Ra{1'b1}})
      return pcPlus4F;
    else if (ctrlW.regWrite && ra == wa3W)
      return resultW;
    return regs[ra];
  endfunction

  function automatic logic [Dw-1:0] fwdOperand(input armPkg::forwardSel sel,
                                               input logic [Dw-1:0] regVal);
    case (sel)
      armPkg::FwdMem: return aluOutM;
      armPkg::FwdWb: return resultW;
      default: return regVal;
    endcase
  endfunction

  assign pcPlus4F = pcF + 4;
  assign fetchPort.valid = fetchEnQ;
  assign fetchPort.req = '{addr: {2'b00, pcF[Dw-1:2]}, wdata: '0, we: 1'b0};
  assign fetchWait = ~fetchPort.ready;  // Lost to the data side, or not yet enabled

  always_ff @(posedge clk) begin
    if (reset) begin
      fetchEnQ <= 1'b0;
      pcF <= '0;
    end else begin
      fetchEnQ <= 1'b1;
      if (!StallF)
        pcF <= BranchTakenE ? aluResultE : pcPlus4F;  // Target comes from the ALU
    end
  end

  always_ff @(posedge clk) begin
    if (reset || FlushD)
      instrD <= NopInstr;
    else if (!StallD)
      instrD <= fetchPort.rdata;
  end

  assign ra1D = regSrcD[0] ? {Ra{1'b1}} : instrD[19:16];  // Branches use R15
  assign ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];  // STR data is Rd

  always_comb begin
    rd1D = readReg(ra1D);
    rd2D = readReg(ra2D);
  end

  assign rotImmD = {2{24'b0, instrD[7:0]}} >> {instrD[11:8], 1'b0};  // Rotate right

  always_comb begin
    case (immSrcD)
      armPkg::ImmMem12: extImmD = {20'b0, instrD[11:0]};
      armPkg::ImmBr24: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
      default: extImmD = rotImmD[Dw-1:0];
    endcase
  end

  always_ff @(posedge clk) begin  // D to E
    rd1E <= rd1D;
    rd2E <= rd2D;
    extImmE <= extImmD;
    ra1E <= ra1D;
    ra2E <= ra2D;
    wa3E <= instrD[15:12];
  end

  always_comb begin
    srcAE = fwdOperand(ForwardAE, rd1E);
    writeDataE = fwdOperand(ForwardBE, rd2E);  // Also the store data
  end

  assign srcBE = ctrlE.aluSrc ? extImmE : writeDataE;

  alu aluE (
    .a(srcAE),
    .b(srcBE),
    .aluControl(armPkg::aluOp'(ctrlE.aluOp)),
    .result(aluResultE),
    .zero(zeroE)
  );

  always_ff @(posedge clk) begin  // E to M
    aluOutM <= aluResultE;
    writeDataM <= writeDataE;
    wa3M <= wa3E;
  end

  // Data side wins over fetch, so M never waits
  assign dataPort.valid = ctrlM.memWrite | ctrlM.memToReg;
  assign dataPort.req = '{addr: {2'b00, aluOutM[Dw-1:2]}, wdata: writeDataM,
                          we: ctrlM.memWrite};

  always_ff @(posedge clk) begin  // M to W
    aluOutW <= aluOutM;
    wa3W <= wa3M;
    if (dataPort.ready)
      readDataW <= dataPort.rdata;
  end

  assign resultW = ctrlW.memToReg ? readDataW : aluOutW;

  always_ff @(posedge clk) begin
    if (ctrlW.regWrite)
      regs[wa3W] <= resultW;
  end

  assign retireValid = ctrlW.regWrite;  // Writeback trace
  assign retireReg = wa3W;
  assign retireData = resultW;

  assign Match1EM = (wa3M == ra1E);
  assign Match1EW = (wa3W == ra1E);
  assign Match2EM = (wa3M == ra2E);
  assign Match2EW = (wa3W == ra2E);
  assign Match12DE = (wa3E == ra1D) | (wa3E == ra2D);  // For load-use
endmodule

// ==== hazardUnit.sv ====
module hazardUnit (
  input logic Match1EM,
  input logic Match1EW,
  input logic Match2EM,
  input logic Match2EW,
  input logic Match12DE,
  input armPkg::stageCtrl ctrlE,
  input armPkg::stageCtrl ctrlM,
  input armPkg::stageCtrl ctrlW,
  input logic fetchWait,
  input logic BranchTakenE,
  output armPkg::forwardSel ForwardAE,
  output armPkg::forwardSel ForwardBE,
  output logic StallF,
  output logic StallD,
  output logic FlushD,
  output logic FlushE
);
  logic ldStall;  // Load in E feeds the instruction in D

  function automatic armPkg::forwardSel pickFwd(input logic hitM, input logic hitW);
    if (hitM)
      return armPkg::FwdMem;  // Younger result wins
    else if (hitW)
      return armPkg::FwdWb;
    return armPkg::FwdNone;
  endfunction

  assign ForwardAE = pickFwd(Match1EM & ctrlM.regWrite, Match1EW & ctrlW.regWrite);
  assign ForwardBE = pickFwd(Match2EM & ctrlM.regWrite, Match2EW & ctrlW.regWrite);

  assign ldStall = Match12DE & ctrlE.memToReg;

  // A taken branch moves the PC even without a fetch grant
  assign StallF = ldStall | (fetchWait & ~BranchTakenE);
  assign StallD = ldStall;
  // Missing fetch leaves a bubble in D, unless D is held
  assign FlushD = BranchTakenE | (fetchWait & ~ldStall);
  assign FlushE = BranchTakenE | ldStall;
endmodule

// ==== controller.sv ====
module controller (
  input logic clk,
  input logic reset,
  input logic [armPkg::DataWidth-1:0] instrD,
  input logic zeroE,
  input logic StallD,
  input logic FlushE,
  output armPkg::stageCtrl ctrlE,
  output armPkg::stageCtrl ctrlM,
  output armPkg::stageCtrl ctrlW,
  output armPkg::immSrc immSrcD,
  output logic [1:0] regSrcD,
  output logic BranchTakenE
);
  localparam logic [3:0] CondEq = 4'h0;
  localparam logic [3:0] CondNe = 4'h1;
  localparam logic [3:0] CondAl = 4'hE;
  localparam logic [3:0] CmdAnd = 4'h0;
  localparam logic [3:0] CmdAdd = 4'h4;
  localparam logic [3:0] CmdCmp = 4'hA;
  localparam logic [3:0] CmdOrr = 4'hC;

  armPkg::stageCtrl ctrlD;
  armPkg::stageCtrl ctrlGatedE;  // E bits after the condition check
  logic zFlagQ;
  logic condOkE;

  always_comb begin
    ctrlD = '0;
    ctrlD.cond = instrD[31:28];
    immSrcD = armPkg::ImmRot;
    regSrcD = 2'b00;
    case (instrD[27:26])
      2'b00: begin  // Data processing
        ctrlD.aluSrc = instrD[25];  // I bit
        ctrlD.flagWrite = (instrD[24:21] == CmdCmp);
        ctrlD.regWrite = (instrD[24:21] != CmdCmp);  // CMP has no Rd
        case (instrD[24:21])
          CmdAdd: ctrlD.aluOp = armPkg::AluAdd;
          CmdAnd: ctrlD.aluOp = armPkg::AluAnd;
          CmdOrr: ctrlD.aluOp = armPkg::AluOr;
          default: ctrlD.aluOp = armPkg::AluSub;  // SUB and CMP
        endcase
      end
      2'b01: begin  // LDR / STR, base plus offset
        ctrlD.aluSrc = 1'b1;
        ctrlD.regWrite = instrD[20];
        ctrlD.memToReg = instrD[20];
        ctrlD.memWrite = ~instrD[20];
        immSrcD = armPkg::ImmMem12;
        regSrcD[1] = ~instrD[20];  // STR reads Rd as store data
      end
      2'b10: begin  // B, BEQ, BNE
        ctrlD.aluSrc = 1'b1;
        ctrlD.branch = 1'b1;
        immSrcD = armPkg::ImmBr24;
        regSrcD[0] = 1'b1;  // Target is R15 plus offset
      end
      default: ;  // Unsupported, runs as a bubble
    endcase
  end

  always_comb begin
    case (ctrlE.cond)
      CondEq: condOkE = zFlagQ;
      CondNe: condOkE = ~zFlagQ;
      CondAl: condOkE = 1'b1;
      default: condOkE = 1'b0;  // D bubbles carry the never code
    endcase
  end

  always_comb begin
    ctrlGatedE = ctrlE;
    ctrlGatedE.regWrite = ctrlE.regWrite & condOkE;
    ctrlGatedE.memWrite = ctrlE.memWrite & condOkE;
    ctrlGatedE.branch = ctrlE.branch & condOkE;
  end

  assign BranchTakenE = ctrlGatedE.branch;

  always_ff @(posedge clk) begin
    // A stalled D must not also move on into E
    if (reset || FlushE || StallD)
      ctrlE <= '0;
    else
      ctrlE <= ctrlD;
    if (reset) begin
      ctrlM <= '0;
      ctrlW <= '0;
      zFlagQ <= 1'b0;
    end else begin
      ctrlM <= ctrlGatedE;
      ctrlW <= ctrlM;
      if (ctrlE.flagWrite)
        zFlagQ <= zeroE;  // Seen by a branch in E next cycle
    end
  end
endmodule

// ==== unifiedMem.sv ====
module unifiedMem #(
  parameter int MemWords = 256
) (
  input logic clk,
  input armPkg::memReq memIn,
  input logic memWe,
  output logic [armPkg::DataWidth-1:0] memRdata
);
  localparam int IdxWidth = $clog2(MemWords);

  logic [armPkg::DataWidth-1:0] words [MemWords];  // Code and data share it
  logic [IdxWidth-1:0] idx;

  assign idx = memIn.addr[IdxWidth-1:0];  // Arbiter already wrapped the address
  assign memRdata = words[idx];  // Asynchronous read

  always_ff @(posedge clk) begin
    if (memWe)
      words[idx] <= memIn.wdata;
  end
endmodule

// ==== memArbiter.sv ====
module memArbiter #(
  parameter int MemWords = 256
) (
  input logic clk,
  input logic reset,
  memBus.arbiter loadPort,
  memBus.arbiter dataPort,
  memBus.arbiter fetchPort,
  output armPkg::memReq memOut,
  output logic memWe,
  input logic [armPkg::DataWidth-1:0] memRdata
);
  logic grantLoad;
  logic grantData;
  logic grantFetch;
  logic loadLastQ;  // Loader wrote in the previous cycle
  armPkg::memReq picked;

  // Fixed priority, loader first and fetch last
  assign grantLoad = loadPort.valid;
  assign grantData = dataPort.valid & ~grantLoad;
  // Fetch also sits out the cycle after a load word,
  // so a loader burst is not split by the core
  assign grantFetch = fetchPort.valid & ~grantLoad & ~dataPort.valid & ~loadLastQ;

  always_ff @(posedge clk) begin
    if (reset)
      loadLastQ <= 1'b0;
    else
      loadLastQ <= grantLoad;
  end

  always_comb begin
    if (grantLoad)
      picked = loadPort.req;
    else if (grantData)
      picked = dataPort.req;
    else
      picked = fetchPort.req;  // Also the idle choice
  end

  assign memOut.addr = picked.addr % MemWords;  // Wrap into the array
  assign memOut.wdata = picked.wdata;
  assign memOut.we = picked.we;
  assign memWe = picked.we & (grantLoad | grantData);  // Fetch never writes

  assign loadPort.ready = grantLoad;
  assign dataPort.ready = grantData;
  assign fetchPort.ready = grantFetch;

  // Read word goes back to the granted port only
  assign loadPort.rdata = grantLoad ? memRdata : '0;
  assign dataPort.rdata = grantData ? memRdata : '0;
  assign fetchPort.rdata = grantFetch ? memRdata : '0;
endmodule

// ==== alu.sv ====
module alu (
  input logic [armPkg::DataWidth-1:0] a,
  input logic [armPkg::DataWidth-1:0] b,
  input armPkg::aluOp aluControl,
  output logic [armPkg::DataWidth-1:0] result,
  output logic zero
);
  always_comb begin
    case (aluControl)
      armPkg::AluAdd: result = a + b;  // ADD, address and branch target
      armPkg::AluSub: result = a - b;  // SUB and CMP
      armPkg::AluAnd: result = a & b;
      default: result = a | b;  // ORR
    endcase
  end

  // Z for CMP
  assign zero = (result == '0);
endmodule

// ==== memBus.sv ====
interface memBus;
  logic valid;  // Request pending
  logic ready;  // Granted in this cycle
  armPkg::memReq req;  // Held steady until ready
  logic [armPkg::DataWidth-1:0] rdata;  // Read word, valid with ready

  modport requester (
    output valid,
    output req,
    input ready,
    input rdata
  );

  modport arbiter (
    input valid,
    input req,
    output ready,
    output rdata
  );
endinterface

// ==== armPkg.sv ====
package armPkg;
  localparam int DataWidth = 32;  // Data and instruction word
  localparam int RegAddrWidth = 4;  // R0..R15

  // ALU operations
  typedef enum logic [1:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr
  } aluOp;

  // Immediate formats
  typedef enum logic [1:0] {
    ImmRot,  // imm8 rotated right by twice the rot field
    ImmMem12,  // Load/store offset, zero extended
    ImmBr24  // Branch offset in words
  } immSrc;

  // ALU operand sources
  typedef enum logic [1:0] {
    FwdNone,  // Value read in D
    FwdWb,  // Result in W
    FwdMem  // ALU result in M
  } forwardSel;

  // Control bits that travel with an instruction from D to W
  typedef struct packed {
    logic regWrite;
    logic memWrite;
    logic memToReg;  // Load result goes to Rd
    logic aluSrc;  // Immediate as operand B
    logic [1:0] aluOp;  // Holds an aluOp code
    logic flagWrite;  // Only CMP sets it
    logic branch;
    logic [3:0] cond;
  } stageCtrl;

  // One request on a memory port
  typedef struct packed {
    logic [DataWidth-1:0] addr;  // Word address
    logic [DataWidth-1:0] wdata;
    logic we;
  } memReq;
endpackage
